// ==== hdl/credit_counters.sv ====
`timescale 1ns/10ps

`include "noc_cfg.svh"

// one credit counter per downstream vc buffer
// send takes a slot, credit gives one back
module credit_counters (
   input  logic                clk,
   input  logic                rst_n,
   input  logic [`NOC_VCN-1:0] send,    // one-hot, same as vca
   input  logic [`NOC_VCN-1:0] credit,  // returns from downstream
   output logic [`NOC_VCN-1:0] avail    // slot free on that vc
);

   import sched_pkg::*;

   logic [`NOC_CW-1:0] cnt [`NOC_VCN];  // free slots per vc

   // counters move at the edge after a send or a return
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         for (int i = 0; i < `NOC_VCN; i++) begin
            cnt[i] <= CREDIT_FULL;  // downstream buffers start empty
         end
      end else begin
         for (int i = 0; i < `NOC_VCN; i++) begin
            case ({send[i], credit[i]})
               2'b10:   cnt[i] <= cnt[i] - 1'b1;  // flit sent
               2'b01:   cnt[i] <= cnt[i] + 1'b1;  // slot returned
               default: cnt[i] <= cnt[i];         // none, or both cancel
            endcase
         end
      end
   end

   // availability straight off the count
   always_comb begin
      for (int i = 0; i < `NOC_VCN; i++) begin
         avail[i] = (cnt[i] != '0);
      end
   end

   // fsm masks out empty vcs, so a send on zero means
   // the mask and the counters disagree
   for (genvar g = 0; g < `NOC_VCN; g++) begin : g_chk
      a_no_underflow: assert property (
         @(posedge clk) disable iff (!rst_n)
         send[g] |-> (cnt[g] != '0)
      ) else $error("credit underflow on vc %0d", g);

      // downstream can't return more than it was given
      // a send in the same cycle frees the slot first
      a_no_overflow: assert property (
         @(posedge clk) disable iff (!rst_n)
         (credit[g] && !send[g]) |-> (cnt[g] != CREDIT_FULL)
      ) else $error("credit overflow on vc %0d", g);

      // counter never leaves its legal range
      a_in_range: assert property (
         @(posedge clk) disable iff (!rst_n)
         cnt[g] <= CREDIT_FULL
      ) else $error("credit count out of range on vc %0d", g);
   end

endmodule

// ==== hdl/flit_out_reg.sv ====
`timescale 1ns/10ps

`include "noc_cfg.svh"

// output register puts the acked lane on the link next cycle
module flit_out_reg (
   input  logic                clk,
   input  logic                rst_n,
   input  logic [`NOC_VCN-1:0] vca,                // one-hot ack
   input  flit_pkg::flit_t     in_flits [`NOC_VCN],
   output flit_pkg::link_t     link
);

   import flit_pkg::*;

   flit_t               sel_flit;  // lane picked by vca
   logic [`NOC_VCW-1:0] sel_vc;    // vca encoded to an index
   logic                valid_q;
   logic [`NOC_VCW-1:0] vc_q;
   flit_t               flit_q;

   // one-hot mux plus encoder
   always_comb begin
      sel_flit = '0;
      sel_vc   = '0;
      for (int i = 0; i < `NOC_VCN; i++) begin
         if (vca[i]) begin
            sel_flit = in_flits[i];
            sel_vc   = i[`NOC_VCW-1:0];
         end
      end
   end

   // valid drops in any cycle without an ack
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) valid_q <= 1'b0;
      else        valid_q <= |vca;
   end

   // tag and payload load on an ack
   always_ff @(posedge clk) begin
      if (|vca) begin
         vc_q   <= sel_vc;
         flit_q <= sel_flit;
      end
   end

   assign link = '{valid: valid_q, vc: vc_q, flit: flit_q};

endmodule

// ==== hdl/flit_pkg.sv ====
`include "noc_cfg.svh"

// what travels on the link: flit opcodes and wire formats
package flit_pkg;

   // position of a flit inside its packet
   typedef enum logic [`NOC_FTW-1:0] {
      FT_HEAD = 2'b00,  // opens a packet, carries the route
      FT_BODY = 2'b01,  // middle of packet
      FT_TAIL = 2'b10   // closes the packet, frees the lock
   } flit_type_e;

   // one flit as presented on an upstream lane
   typedef struct packed {
      flit_type_e          ftype;  // head / body / tail
      logic [`NOC_DW-1:0]  data;   // payload, untouched by the port
   } flit_t;

   // registered link word, one per cycle at most
   typedef struct packed {
      logic                valid;  // flit present this cycle
      logic [`NOC_VCW-1:0] vc;     // downstream buffer it belongs to
      flit_t               flit;
   } link_t;

   // keep the struct widths in step with the cfg header
   localparam int FLIT_W = $bits(flit_t);   // 34
   localparam int LINK_W = $bits(link_t);   // 37

endpackage

// ==== hdl/noc_cfg.svh ====
`ifndef NOC_CFG_SVH
`define NOC_CFG_SVH

// link payload, one flit per cycle
`define NOC_DW 32

// virtual channels sharing the link
`define NOC_VCN 4

// vc index width, log2 of NOC_VCN
`define NOC_VCW 2

// slots in each downstream vc buffer
`define NOC_CREDIT_DEPTH 4

// must hold 0..NOC_CREDIT_DEPTH inclusive
`define NOC_CW 3

// widths of the flit fields on the wire
`define NOC_FTW 2                           // flit type opcode
`define NOC_FLITW (`NOC_FTW + `NOC_DW)      // type + payload
`define NOC_LINKW (1 + `NOC_VCW + `NOC_FLITW) // valid + vc + flit

`endif

// ==== hdl/outpbuf.sv ====
`timescale 1ns/10ps

`include "noc_cfg.svh"

// output port of one router link
// credits gate the vcs, the fsm keeps packets whole,
// the arbiter rotates between packets, one flit per cycle out
module outpbuf (
   input  logic                clk,
   input  logic                rst_n,
   input  flit_pkg::flit_t     in_flits [`NOC_VCN], // one lane per vc
   input  logic [`NOC_VCN-1:0] vcr,                // request levels
   output logic [`NOC_VCN-1:0] vca,                // ack pulses
   output flit_pkg::link_t     link,               // registered link word
   input  logic [`NOC_VCN-1:0] credit,             // credit returns
   output logic [`NOC_VCN-1:0] credit_avail        // vc has a free slot
);

   import sched_pkg::*;

   logic [`NOC_VCN-1:0] req_mask;  // fsm -> arbiter
   grant_t              grant;     // arbiter -> fsm

   credit_counters i_credit (
      .clk    (clk),
      .rst_n  (rst_n),
      .send   (vca),           // each ack spends one credit
      .credit (credit),
      .avail  (credit_avail)
   );

   vc_arbiter i_arb (
      .clk      (clk),
      .rst_n    (rst_n),
      .req_mask (req_mask),
      .grant    (grant)
   );

   pkt_sched_fsm i_fsm (
      .clk      (clk),
      .rst_n    (rst_n),
      .vcr      (vcr),
      .in_flits (in_flits),
      .avail    (credit_avail),
      .grant    (grant),
      .req_mask (req_mask),
      .vca      (vca)
   );

   flit_out_reg i_oreg (
      .clk      (clk),
      .rst_n    (rst_n),
      .vca      (vca),
      .in_flits (in_flits),
      .link     (link)
   );

endmodule

// ==== hdl/pkt_sched_fsm.sv ====
`timescale 1ns/10ps

`include "noc_cfg.svh"

// packet scheduler: keeps packets whole on the link
// builds the request mask, grant comes back as vca
module pkt_sched_fsm (
   input  logic                clk,
   input  logic                rst_n,
   input  logic [`NOC_VCN-1:0] vcr,                // upstream request levels
   input  flit_pkg::flit_t     in_flits [`NOC_VCN], // head flit per lane
   input  logic [`NOC_VCN-1:0] avail,              // credit free per vc
   input  sched_pkg::grant_t   grant,              // from the arbiter
   output logic [`NOC_VCN-1:0] req_mask,           // to the arbiter
   output logic [`NOC_VCN-1:0] vca                 // ack, same cycle as grant
);

   import flit_pkg::*;
   import sched_pkg::*;

   sched_state_e        state;
   logic [`NOC_VCW-1:0] lock_vc;   // vc owning the link while locked
   logic [`NOC_VCN-1:0] lock_oh;   // same, one-hot
   logic [`NOC_VCN-1:0] elig;      // requesting and has credit
   logic [`NOC_VCW-1:0] gnt_idx;   // index of the granted lane
   flit_type_e          gnt_type;  // type of the granted flit

   assign elig    = vcr & avail;  // no credit, no request
   assign lock_oh = {{(`NOC_VCN-1){1'b0}}, 1'b1} << lock_vc;

   // open: anyone eligible, locked: only the owner
   always_comb begin
      if (state == ST_OPEN) req_mask = elig;
      else                  req_mask = elig & lock_oh;
   end

   // winner lane and its flit type
   always_comb begin
      gnt_idx = '0;
      for (int i = 0; i < `NOC_VCN; i++) begin
         if (grant.gnt[i]) gnt_idx = i[`NOC_VCW-1:0];
      end
   end

   assign gnt_type = in_flits[gnt_idx].ftype;

   assign vca = grant.gnt;  // ack in the cycle of selection

   // lock on head, release on tail
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state   <= ST_OPEN;
         lock_vc <= '0;
      end else begin
         case (state)
            ST_OPEN: begin
               if (grant.hit && gnt_type == FT_HEAD) begin
                  state   <= ST_LOCKED;
                  lock_vc <= gnt_idx;  // remember the owner
               end
            end
            ST_LOCKED: begin
               if (grant.hit && gnt_type == FT_TAIL) begin
                  state <= ST_OPEN;    // packet done, round robin again
               end
            end
            default: state <= ST_OPEN;
         endcase
      end
   end

   // between packets upstream must present a head
   a_open_head: assert property (
      @(posedge clk) disable iff (!rst_n)
      (state == ST_OPEN && grant.hit) |-> (gnt_type == FT_HEAD)
   ) else $error("non-head flit started a packet on vc %0d", gnt_idx);

   // a second head inside a packet would break the lock
   a_locked_no_head: assert property (
      @(posedge clk) disable iff (!rst_n)
      (state == ST_LOCKED && grant.hit) |-> (gnt_type != FT_HEAD)
   ) else $error("head flit inside a packet on vc %0d", gnt_idx);

endmodule

// ==== hdl/sched_pkg.sv ====
`include "noc_cfg.svh"

// port control side: scheduler state and arbiter result
package sched_pkg;

   // packet-level lock of the output link
   typedef enum logic [0:0] {
      ST_OPEN   = 1'b0,  // between packets, any vc may start
      ST_LOCKED = 1'b1   // a packet is in progress on one vc
   } sched_state_e;

   // arbiter answer, combinational back to the fsm
   typedef struct packed {
      logic                hit;  // some vc wins this cycle
      logic [`NOC_VCN-1:0] gnt;  // one-hot winner
   } grant_t;

   // reset value of the last-winner pointer
   // vc 0 then ranks first after reset
   localparam logic [`NOC_VCW-1:0] LAST_RST = `NOC_VCW'(`NOC_VCN - 1);

   // full credit count, loaded at reset
   localparam logic [`NOC_CW-1:0] CREDIT_FULL = `NOC_CW'(`NOC_CREDIT_DEPTH);

endpackage

// ==== hdl/vc_arbiter.sv ====
`timescale 1ns/10ps

`include "noc_cfg.svh"

// round-robin over the masked requests
// search starts one past the last winner and wraps
module vc_arbiter (
   input  logic                clk,
   input  logic                rst_n,
   input  logic [`NOC_VCN-1:0] req_mask,  // eligible vcs from the fsm
   output sched_pkg::grant_t   grant      // combinational answer
);

   import sched_pkg::*;

   logic [`NOC_VCW-1:0] last_q;   // last winner
   logic [`NOC_VCW-1:0] win_idx;  // this cycle's winner if any
   grant_t              nxt;

   // first requester found after last_q wins
   always_comb begin
      int idx;
      nxt     = '0;
      win_idx = last_q;
      for (int k = 1; k <= `NOC_VCN; k++) begin
         idx = (int'(last_q) + k) % `NOC_VCN;  // wrap around
         if (!nxt.hit && req_mask[idx]) begin
            nxt.hit      = 1'b1;
            nxt.gnt[idx] = 1'b1;
            win_idx      = idx[`NOC_VCW-1:0];
         end
      end
   end

   assign grant = nxt;

   // pointer only moves when someone is served
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         last_q <= LAST_RST;  // vc 0 first
      end else if (nxt.hit) begin
         last_q <= win_idx;
      end
   end

   // grant is well formed and never goes to a non-requester
   a_grant_ok: assert property (
      @(posedge clk) disable iff (!rst_n)
      $onehot0(grant.gnt) && (grant.hit == |grant.gnt) &&
      ((grant.gnt & ~req_mask) == '0)
   ) else $error("bad grant %b for mask %b", grant.gnt, req_mask);

endmodule

// ==== project.f ====
+incdir+hdl
hdl/flit_pkg.sv
hdl/sched_pkg.sv
hdl/credit_counters.sv
hdl/vc_arbiter.sv
hdl/pkt_sched_fsm.sv
hdl/flit_out_reg.sv
hdl/outpbuf.sv
verification/outpbuf_tb.sv

// ==== verification/outpbuf_cases.txt ====
# flit <vc> <head|body|tail> <hex data> = upstream flit; expect <vc> <type> <hex data> = next link flit
# credit <vc> <cycle> = return pulse in that case cycle; gap <n> = max idle; stream = no idle link
gap 3
flit 2 head 2a000001
flit 2 body 2b000002
flit 2 tail 2c000003
expect 2 head 2a000001
expect 2 body 2b000002
expect 2 tail 2c000003
end
gap 2
flit 3 head 3a000030
flit 3 tail 3c000031
flit 1 head 1a000010
flit 1 body 1b000011
flit 1 tail 1c000012
flit 0 head 0a000000
flit 0 tail 0c000001
expect 0 head 0a000000
expect 0 tail 0c000001
expect 1 head 1a000010
expect 1 body 1b000011
expect 1 tail 1c000012
expect 3 head 3a000030
expect 3 tail 3c000031
end
gap 0
flit 1 head 1a0000a0
flit 1 body 1b0000a1
flit 1 body 1b0000a2
flit 1 body 1b0000a3
flit 1 tail 1c0000a4
flit 3 head 3a0000b0
flit 3 tail 3c0000b1
credit 1 12
expect 1 head 1a0000a0
expect 1 body 1b0000a1
expect 1 body 1b0000a2
expect 1 body 1b0000a3
expect 1 tail 1c0000a4
expect 3 head 3a0000b0
expect 3 tail 3c0000b1
end
gap 0
stream
flit 0 head 0a0000d0
flit 0 body 0b0000d1
flit 0 tail 0c0000d2
flit 2 head 2a0000e0
flit 2 tail 2c0000e1
credit 0 0
credit 0 1
credit 0 2
credit 2 3
credit 2 4
expect 0 head 0a0000d0
expect 0 body 0b0000d1
expect 0 tail 0c0000d2
expect 2 head 2a0000e0
expect 2 tail 2c0000e1
end

// ==== verification/outpbuf_tb.sv ====
`timescale 1ns/10ps

`include "noc_cfg.svh"

module outpbuf_tb;

   import flit_pkg::*;

   localparam int QMAX = 16;  // flits per vc per case
   localparam int EMAX = 32;  // link flits / credit pulses per case
   localparam int TMO  = 60;  // cycles allowed for any single wait

   logic                clk = 1'b0;
   logic                rst_n;
   flit_t               in_flits [`NOC_VCN];
   logic [`NOC_VCN-1:0] vcr;
   logic [`NOC_VCN-1:0] vca;
   link_t               link;
   logic [`NOC_VCN-1:0] credit;
   logic [`NOC_VCN-1:0] credit_avail;

   flit_t               up_q [`NOC_VCN][QMAX];  // upstream flits per lane
   int                  up_n [`NOC_VCN];
   int                  up_rd [`NOC_VCN];        // next flit to present
   int                  gap_cnt [`NOC_VCN];      // idle cycles still to wait
   int                  cr_vc [EMAX];
   int                  cr_cyc [EMAX];
   int                  cr_n;
   int                  exp_vc [EMAX];           // in-order link list
   flit_t               exp_flit [EMAX];
   int                  exp_n;
   int                  exp_rd;
   int                  gap_max;
   logic                stream;                  // no idle link cycle allowed
   logic                run;
   int                  cyc;                     // cycles since case start
   int                  last_cyc;
   int                  case_no;
   integer              seed = 12172;
   logic [`NOC_VCN-1:0] ack_q;                   // vca of the previous cycle
   int                  ack_vc;
   flit_t               ack_flit;
   int                  cnt_model [`NOC_VCN];    // expected free slots

   always #5 clk = ~clk;

   outpbuf i_dut (
      .clk          (clk),
      .rst_n        (rst_n),
      .in_flits     (in_flits),
      .vcr          (vcr),
      .vca          (vca),
      .link         (link),
      .credit       (credit),
      .credit_avail (credit_avail)
   );

   task automatic abort_run();
      $display("FAIL: see errors above");
      $fatal(1, "run stopped at the first error");
   endtask

   task automatic value_error(input string sig, input logic [63:0] exp_v,
                              input logic [63:0] act_v);
      $display("error: %0d ns: %s expected %0h, got %0h", $time, sig, exp_v, act_v);
      abort_run();
   endtask

   task automatic report_failure(input string what);
      $display("error: %0d ns: %s", $time, what);
      abort_run();
   endtask

   task automatic decode_type(input string s, output flit_type_e t);
      t = FT_HEAD;
      case (s)
         "head":  t = FT_HEAD;
         "body":  t = FT_BODY;
         "tail":  t = FT_TAIL;
         default: report_failure({"unknown flit type in case file: ", s});
      endcase
   endtask

   task automatic clear_case();
      for (int i = 0; i < `NOC_VCN; i++) begin
         up_n[i]    = 0;
         up_rd[i]   = 0;
         gap_cnt[i] = 0;
      end
      cr_n    = 0;
      exp_n   = 0;
      exp_rd  = 0;
      gap_max = 0;
      stream  = 1'b0;
   endtask

   // all lanes empty, vcr dropped, every credit pulse issued
   function automatic logic drained();
      logic d;
      d = (vcr == '0);
      for (int i = 0; i < `NOC_VCN; i++) begin
         if (up_rd[i] != up_n[i]) d = 1'b0;
      end
      for (int k = 0; k < cr_n; k++) begin
         if (cr_cyc[k] >= cyc) d = 1'b0;  // cyc runs one ahead at negedge
      end
      return d;
   endfunction

   task automatic apply_reset();
      @(posedge clk);
      rst_n <= 1'b0;
      repeat (2) @(posedge clk);
      rst_n <= 1'b1;
      @(negedge clk);
      assert (link.valid == 1'b0) else value_error("link.valid", 0, link.valid);
      assert (vca == '0) else value_error("vca", 0, vca);
      assert (credit_avail == '1)
         else value_error("credit_avail", {`NOC_VCN{1'b1}}, credit_avail);
   endtask

   task automatic run_case();
      int t;
      int seen;
      apply_reset();
      @(posedge clk);
      run <= 1'b1;
      while (exp_rd < exp_n) begin
         seen = exp_rd;
         t    = 0;
         while (exp_rd == seen) begin
            @(posedge clk);  // exp_rd moves on the negedge
            t = t + 1;
            if (t > TMO) report_failure($sformatf(
               "case %0d: link flit %0d never appeared", case_no, seen));
         end
      end
      t = 0;
      while (!drained()) begin
         @(negedge clk);
         t = t + 1;
         if (t > TMO) report_failure($sformatf(
            "case %0d: upstream flits or credit pulses never finished", case_no));
      end
      repeat (3) @(posedge clk);  // stray link flits get caught here
      run <= 1'b0;
      @(posedge clk);  // lanes and credit pulses see run low before the next case loads
   endtask

   // upstream lanes hold a flit until acked and then may idle
   always @(posedge clk) begin
      logic [`NOC_VCN-1:0] nv;
      logic                taken;
      nv = '0;
      if (run) begin
         for (int i = 0; i < `NOC_VCN; i++) begin
            taken = vcr[i] && ack_q[i];
            if (taken) begin
               up_rd[i]   = up_rd[i] + 1;
               gap_cnt[i] = (gap_max > 0) ? int'({$random(seed)} % (gap_max + 1)) : 0;
            end
            if (vcr[i] && !taken) begin
               nv[i] = 1'b1;                      // still waiting for vca
            end else if (gap_cnt[i] > 0) begin
               gap_cnt[i] = gap_cnt[i] - 1;
            end else if (up_rd[i] < up_n[i]) begin
               nv[i]       = 1'b1;
               in_flits[i] <= up_q[i][up_rd[i]];
            end
         end
      end
      vcr <= nv;
   end

   // credit pulses at fixed case cycles
   always @(posedge clk) begin
      logic [`NOC_VCN-1:0] nc;
      nc = '0;
      if (run) begin
         for (int k = 0; k < cr_n; k++) begin
            if (cr_cyc[k] == cyc) nc[cr_vc[k]] = 1'b1;
         end
      end
      credit <= nc;
      cyc    <= run ? cyc + 1 : 0;
   end

   // link checker and credit model sampled mid-cycle
   always @(negedge clk) begin
      logic [`NOC_VCN-1:0] av;
      if (!rst_n) begin
         ack_q = '0;
         for (int i = 0; i < `NOC_VCN; i++) cnt_model[i] = `NOC_CREDIT_DEPTH;
      end else if (run) begin
         assert (link.valid == |ack_q) else value_error("link.valid", |ack_q, link.valid);
         if (link.valid) begin
            assert (link.vc == ack_vc) else value_error("link.vc", ack_vc, link.vc);
            assert (link.flit == ack_flit) else value_error("link.flit", ack_flit, link.flit);
            if (exp_rd >= exp_n) begin
               report_failure("link carried a flit past the end of the expected list");
            end else begin
               assert (link.vc == exp_vc[exp_rd])
                  else value_error("link.vc", exp_vc[exp_rd], link.vc);
               assert (link.flit == exp_flit[exp_rd])
                  else value_error("link.flit", exp_flit[exp_rd], link.flit);
               if (stream && exp_rd > 0) begin
                  assert (cyc == last_cyc + 1)
                     else report_failure("idle link cycle inside a back-to-back stream");
               end
               last_cyc = cyc;
               exp_rd   = exp_rd + 1;
            end
         end
         for (int i = 0; i < `NOC_VCN; i++) av[i] = (cnt_model[i] != 0);
         assert (credit_avail == av) else value_error("credit_avail", av, credit_avail);
         assert ($onehot0(vca)) else report_failure("vca acknowledged more than one vc");
         assert ((vca & ~(vcr & av)) == '0)
            else report_failure("vca acknowledged a vc without request or credit");
         ack_q = vca;  // flit must show on link next cycle
         for (int i = 0; i < `NOC_VCN; i++) begin
            if (vca[i]) begin
               ack_vc   = i;
               ack_flit = in_flits[i];
            end
            if (vca[i] && !credit[i]) cnt_model[i] = cnt_model[i] - 1;
            if (!vca[i] && credit[i]) cnt_model[i] = cnt_model[i] + 1;
         end
      end
   end

   initial begin
      string              line;
      string              kw;
      string              ts;
      int                 fd;
      int                 n;
      int                 vc;
      int                 cy;
      logic [`NOC_DW-1:0] d;
      flit_type_e         ft;
      rst_n   = 1'b0;
      vcr     = '0;
      credit  = '0;
      run     = 1'b0;
      cyc     = 0;
      ack_q   = '0;
      case_no = 0;
      for (int i = 0; i < `NOC_VCN; i++) in_flits[i] = '0;
      clear_case();
      fd = $fopen("verification/outpbuf_cases.txt", "r");
      if (fd == 0) report_failure("cannot open verification/outpbuf_cases.txt");
      while (!$feof(fd)) begin
         line = "";
         kw   = "";
         n    = $fgets(line, fd);
         if (n > 0) n = $sscanf(line, "%s", kw);
         if (n < 1 || kw.len() == 0 || kw[0] == "#") begin
            // blank or comment
         end else if (kw == "flit" || kw == "expect") begin
            n = $sscanf(line, "%s %d %s %h", kw, vc, ts, d);
            if (n != 4 || vc < 0 || vc >= `NOC_VCN || exp_n >= EMAX)
               report_failure({"malformed case line: ", line});
            decode_type(ts, ft);
            if (kw == "flit") begin
               up_q[vc][up_n[vc]] = '{ftype: ft, data: d};
               up_n[vc]           = up_n[vc] + 1;
            end else begin
               exp_vc[exp_n]   = vc;
               exp_flit[exp_n] = '{ftype: ft, data: d};
               exp_n           = exp_n + 1;
            end
         end else if (kw == "credit") begin
            n = $sscanf(line, "%s %d %d", kw, vc, cy);
            if (n != 3 || vc < 0 || vc >= `NOC_VCN || cr_n >= EMAX)
               report_failure({"malformed case line: ", line});
            cr_vc[cr_n]  = vc;
            cr_cyc[cr_n] = cy;
            cr_n         = cr_n + 1;
         end else if (kw == "gap") begin
            n = $sscanf(line, "%s %d", kw, gap_max);
         end else if (kw == "stream") begin
            stream = 1'b1;
         end else if (kw == "end") begin
            case_no = case_no + 1;
            run_case();
            clear_case();
         end else begin
            report_failure({"unknown keyword in case file: ", kw});
         end
      end
      $fclose(fd);
      if (case_no == 0) begin
         report_failure("case file held no complete case");
      end else begin
         $display("PASS: all tests");
         $finish;
      end
   end

endmodule
